//--- Makefile
VERILATOR  ?= verilator
TB_TOP     ?= raster_tb
RTL_TOP    ?= raster_top
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Verification passed
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter src/%,$(SRCS))

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(OBJ_DIR)/V$(TB_TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- list.f
src/raster_pkg.sv
src/line_if.sv
src/line_stepper.sv
src/triangle_rasteriser.sv
src/raster_regs.sv
src/raster_top.sv
verif/raster_tb.sv

//--- src/line_if.sv
// Line stepper bundle
`timescale 1ns/1ns

interface line_if;

	logic               load; // Latch endpoints.
	logic               step; // One Bresenham move.
	raster_pkg::coord_t x0;
	raster_pkg::coord_t y0;
	raster_pkg::coord_t x1;
	raster_pkg::coord_t y1;

	raster_pkg::coord_t x;    // Current point.
	raster_pkg::coord_t y;
	logic               last; // Current point is the end point.

	modport driver (
		output load, step, x0, y0, x1, y1,
		input  x, y, last
	);

	modport stepper (
		input  load, step, x0, y0, x1, y1,
		output x, y, last
	);

endinterface

//--- src/line_stepper.sv
// Bresenham line walker
`timescale 1ns/1ns

module line_stepper (
	input logic     clk,
	input logic     reset,
	line_if.stepper ln
);

	// Wide enough for a doubled error term on a 16-bit grid.
	logic signed [18:0] diff_x;
	logic signed [18:0] diff_y;
	logic signed [18:0] dx_load;
	logic signed [18:0] dy_load;

	logic signed [18:0] dx;  // Positive span along x.
	logic signed [18:0] dy;  // Negative span along y.
	logic signed [18:0] err;
	logic signed [18:0] e2;
	logic signed [18:0] err_next;
	logic               sx_neg;
	logic               sy_neg;
	logic               x_move;
	logic               y_move;

	raster_pkg::coord_t xe; // End point.
	raster_pkg::coord_t ye;

	// Deltas of the new line.
	always_comb
	begin
		diff_x = $signed({3'b000, ln.x1}) - $signed({3'b000, ln.x0});
		diff_y = $signed({3'b000, ln.y1}) - $signed({3'b000, ln.y0});
		dx_load = (diff_x < 0) ? -diff_x : diff_x;
		dy_load = (diff_y < 0) ? diff_y : -diff_y;
	end

	// Which axes move on this step.
	always_comb
	begin
		e2 = err <<< 1;
		x_move = (e2 >= dy);
		y_move = (e2 <= dx);
		err_next = err;
		if (x_move)
		begin
			err_next = err_next + dy;
		end
		if (y_move)
		begin
			err_next = err_next + dx;
		end
	end

	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
		begin
			ln.x   <= '0;
			ln.y   <= '0;
			xe     <= '0;
			ye     <= '0;
			dx     <= '0;
			dy     <= '0;
			err    <= '0;
			sx_neg <= 1'b0;
			sy_neg <= 1'b0;
		end
		else if (ln.load)
		begin
			ln.x   <= ln.x0;
			ln.y   <= ln.y0;
			xe     <= ln.x1;
			ye     <= ln.y1;
			dx     <= dx_load;
			dy     <= dy_load;
			err    <= dx_load + dy_load;
			sx_neg <= (diff_x < 0);
			sy_neg <= (diff_y < 0);
		end
		else if (ln.step && !ln.last)
		begin
			err <= err_next;
			if (x_move)
			begin
				ln.x <= sx_neg ? ln.x - 16'd1 : ln.x + 16'd1;
			end
			if (y_move)
			begin
				ln.y <= sy_neg ? ln.y - 16'd1 : ln.y + 16'd1;
			end
		end
	end

	assign ln.last = (ln.x == xe) && (ln.y == ye);

	// The driver never loads and steps together.
	a_no_step_on_load: assert property (
		@(posedge clk) disable iff (!reset)
		!(ln.load && ln.step)
	);

endmodule

//--- src/raster_pkg.sv
// Rasteriser shared definitions
package raster_pkg;

	// Unsigned pixel coordinate.
	typedef logic [15:0] coord_t;

	// Wishbone word address width.
	localparam int REG_ADDR_W = 3;

	// Vertex registers.
	localparam logic [REG_ADDR_W-1:0] REG_X1 = 3'd0;
	localparam logic [REG_ADDR_W-1:0] REG_Y1 = 3'd1;
	localparam logic [REG_ADDR_W-1:0] REG_X2 = 3'd2;
	localparam logic [REG_ADDR_W-1:0] REG_Y2 = 3'd3;
	localparam logic [REG_ADDR_W-1:0] REG_X3 = 3'd4;
	localparam logic [REG_ADDR_W-1:0] REG_Y3 = 3'd5;

	// Command and status words.
	localparam logic [REG_ADDR_W-1:0] REG_CTRL   = 3'd6;
	localparam logic [REG_ADDR_W-1:0] REG_STATUS = 3'd7;

	// Write 1 to start a triangle.
	localparam int CTRL_START_BIT = 0;

	// Status layout.
	localparam int STAT_BUSY_BIT  = 0;
	localparam int STAT_COUNT_LSB = 16; // Pixels of last triangle.
	localparam int STAT_COUNT_MSB = 31;

	// Width of the status count field.
	localparam int STAT_COUNT_W = STAT_COUNT_MSB - STAT_COUNT_LSB + 1;

endpackage

//--- src/raster_regs.sv
// Rasteriser register block
`timescale 1ns/1ns

module raster_regs #(
	parameter int PIX_ADDR_W = 19
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              wb_cyc,
	input  logic                              wb_stb,
	input  logic                              wb_we,
	input  logic [raster_pkg::REG_ADDR_W-1:0] wb_adr,
	input  logic [31:0]                       wb_dat_w,
	output logic [31:0]                       wb_dat_r,
	output logic                              wb_ack,
	output raster_pkg::coord_t                x1,
	output raster_pkg::coord_t                y1,
	output raster_pkg::coord_t                x2,
	output raster_pkg::coord_t                y2,
	output raster_pkg::coord_t                x3,
	output raster_pkg::coord_t                y3,
	output logic                              start,
	input  logic                              busy,
	input  logic                              done,
	input  logic                              pix_fire
);

	localparam int CW = raster_pkg::STAT_COUNT_W;

	logic                  req;
	logic                  wr;
	logic [PIX_ADDR_W:0]   run_count; // Room for a full frame.
	logic [CW-1:0]         last_count;
	logic [31:0]           status;

	assign req = wb_cyc && wb_stb && !wb_ack; // New access this cycle.
	assign wr  = req && wb_we;

	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
		begin
			wb_ack     <= 1'b0;
			start      <= 1'b0;
			run_count  <= '0;
			last_count <= '0;
		end
		else
		begin
			wb_ack <= req;
			start  <= wr && (wb_adr == raster_pkg::REG_CTRL) &&
				wb_dat_w[raster_pkg::CTRL_START_BIT] && !busy && !start;
			if (start)
			begin
				run_count <= '0;
			end
			else if (pix_fire)
			begin
				run_count <= run_count + 1'b1;
			end
			if (done) // Saturate into the status field.
			begin
				last_count <= (run_count > CW'('1)) ? '1 : CW'(run_count);
			end
		end
	end

	// Vertex storage.
	always_ff @(posedge clk)
	begin
		if (wr)
		begin
			case (wb_adr)
				raster_pkg::REG_X1: x1 <= wb_dat_w[15:0];
				raster_pkg::REG_Y1: y1 <= wb_dat_w[15:0];
				raster_pkg::REG_X2: x2 <= wb_dat_w[15:0];
				raster_pkg::REG_Y2: y2 <= wb_dat_w[15:0];
				raster_pkg::REG_X3: x3 <= wb_dat_w[15:0];
				raster_pkg::REG_Y3: y3 <= wb_dat_w[15:0];
				default: ;
			endcase
		end
	end

	always_comb
	begin
		status = '0;
		status[raster_pkg::STAT_BUSY_BIT] = busy;
		status[raster_pkg::STAT_COUNT_MSB:raster_pkg::STAT_COUNT_LSB] = last_count;
	end

	// Read mux.
	always_comb
	begin
		case (wb_adr)
			raster_pkg::REG_X1:     wb_dat_r = 32'(x1);
			raster_pkg::REG_Y1:     wb_dat_r = 32'(y1);
			raster_pkg::REG_X2:     wb_dat_r = 32'(x2);
			raster_pkg::REG_Y2:     wb_dat_r = 32'(y2);
			raster_pkg::REG_X3:     wb_dat_r = 32'(x3);
			raster_pkg::REG_Y3:     wb_dat_r = 32'(y3);
			raster_pkg::REG_STATUS: wb_dat_r = status;
			default:                wb_dat_r = '0; // Control reads as zero.
		endcase
	end

	// Single-cycle acknowledge.
	a_ack_pulse: assert property (
		@(posedge clk) disable iff (!reset)
		wb_ack |=> !wb_ack
	);

endmodule

//--- src/raster_top.sv
// Triangle rasteriser top level
`timescale 1ns/1ns

module raster_top #(
	parameter int FRAME_WIDTH = 640,
	parameter int PIX_ADDR_W  = 19
) (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              wb_cyc,
	input  logic                              wb_stb,
	input  logic                              wb_we,
	input  logic [raster_pkg::REG_ADDR_W-1:0] wb_adr,
	input  logic [31:0]                       wb_dat_w,
	output logic [31:0]                       wb_dat_r,
	output logic                              wb_ack,
	output logic                              pix_valid,
	output logic [PIX_ADDR_W-1:0]             pix_addr,
	input  logic                              pix_ready
);

	raster_pkg::coord_t x1;
	raster_pkg::coord_t y1;
	raster_pkg::coord_t x2;
	raster_pkg::coord_t y2;
	raster_pkg::coord_t x3;
	raster_pkg::coord_t y3;
	logic               start;
	logic               busy;
	logic               done;
	logic               pix_fire;

	raster_regs #(.PIX_ADDR_W(PIX_ADDR_W)) regs (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.x1(x1), .y1(y1), .x2(x2), .y2(y2), .x3(x3), .y3(y3),
		.start(start), .busy(busy), .done(done), .pix_fire(pix_fire)
	);

	// Scan engine.
	triangle_rasteriser #(
		.FRAME_WIDTH(FRAME_WIDTH),
		.PIX_ADDR_W(PIX_ADDR_W)
	) raster (
		.clk(clk), .reset(reset), .start(start),
		.x1(x1), .y1(y1), .x2(x2), .y2(y2), .x3(x3), .y3(y3),
		.pix_ready(pix_ready), .pix_valid(pix_valid), .pix_addr(pix_addr),
		.busy(busy), .done(done), .pix_fire(pix_fire)
	);

endmodule

//--- src/triangle_rasteriser.sv
// Triangle scan engine
`timescale 1ns/1ns

module triangle_rasteriser #(
	parameter int FRAME_WIDTH = 640,
	parameter int PIX_ADDR_W  = 19
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  raster_pkg::coord_t    x1,
	input  raster_pkg::coord_t    y1,
	input  raster_pkg::coord_t    x2,
	input  raster_pkg::coord_t    y2,
	input  raster_pkg::coord_t    x3,
	input  raster_pkg::coord_t    y3,
	input  logic                  pix_ready,
	output logic                  pix_valid,
	output logic [PIX_ADDR_W-1:0] pix_addr,
	output logic                  busy,
	output logic                  done,
	output logic                  pix_fire
);

	localparam logic [PIX_ADDR_W-1:0] FW = PIX_ADDR_W'(FRAME_WIDTH);

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOAD_EDGES,
		S_LOAD_SPAN,
		S_EMIT,
		S_ADVANCE,
		S_FINISH
	} state_t;

	state_t state;
	state_t next_state;
	logic   both_last;

	line_if ea_if ();
	line_if eb_if ();
	line_if sp_if ();

	line_stepper edge_a (.clk(clk), .reset(reset), .ln(ea_if.stepper));
	line_stepper edge_b (.clk(clk), .reset(reset), .ln(eb_if.stepper));
	line_stepper span   (.clk(clk), .reset(reset), .ln(sp_if.stepper));

	assign both_last = ea_if.last && eb_if.last;

	// Edge A runs v1 to v3.
	assign ea_if.load = (state == S_LOAD_EDGES);
	assign ea_if.x0   = x1;
	assign ea_if.y0   = y1;
	assign ea_if.x1   = x3;
	assign ea_if.y1   = y3;
	assign ea_if.step = (state == S_ADVANCE) && !both_last && !ea_if.last;

	// Edge B runs v2 to v3.
	assign eb_if.load = (state == S_LOAD_EDGES);
	assign eb_if.x0   = x2;
	assign eb_if.y0   = y2;
	assign eb_if.x1   = x3;
	assign eb_if.y1   = y3;
	assign eb_if.step = (state == S_ADVANCE) && !both_last && !eb_if.last;

	// Span joins the two current edge points.
	assign sp_if.load = (state == S_LOAD_SPAN);
	assign sp_if.x0   = ea_if.x;
	assign sp_if.y0   = ea_if.y;
	assign sp_if.x1   = eb_if.x;
	assign sp_if.y1   = eb_if.y;
	assign sp_if.step = (state == S_EMIT) && pix_ready && !sp_if.last; // Held under stall.

	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
		begin
			state <= S_IDLE;
		end
		else
		begin
			state <= next_state;
		end
	end

	always_comb
	begin
		next_state = state;
		case (state)
			S_IDLE:
			begin
				if (start)
				begin
					next_state = S_LOAD_EDGES;
				end
			end
			S_LOAD_EDGES: next_state = S_LOAD_SPAN;
			S_LOAD_SPAN:  next_state = S_EMIT;
			S_EMIT:
			begin
				if (pix_ready && sp_if.last)
				begin
					next_state = S_ADVANCE;
				end
			end
			// Both edges at v3 means the v3 span is already out.
			S_ADVANCE:    next_state = both_last ? S_FINISH : S_LOAD_SPAN;
			S_FINISH:     next_state = S_IDLE;
			default:      next_state = S_IDLE;
		endcase
	end

	assign pix_valid = (state == S_EMIT);
	assign pix_fire  = pix_valid && pix_ready;
	assign busy      = (state != S_IDLE);
	assign done      = (state == S_FINISH);
	assign pix_addr  = FW * PIX_ADDR_W'(sp_if.y) + PIX_ADDR_W'(sp_if.x);

	// Stalled pixel holds its address.
	a_stall_stable: assert property (
		@(posedge clk) disable iff (!reset)
		(pix_valid && !pix_ready) |=> (pix_valid && $stable(pix_addr))
	);

	// Completion only ends a run.
	a_done_after_busy: assert property (
		@(posedge clk) disable iff (!reset)
		done |-> $past(busy)
	);

endmodule

//--- verif/raster_cases.txt
# Each line holds x1 y1 x2 y2 x3 y3 then the pixel count and the address sum.
# All values are decimal and the sum wraps at 32 bits.
5 5 5 5 5 5 1 3205
0 0 2 0 0 2 6 2564
10 3 13 4 11 6 10 28912
639 479 636 479 638 477 7 2147823
100 50 108 50 104 52 25 815400
20 10 20 14 24 12 13 100116
0 0 0 0 0 0 1 0
639 479 639 479 639 479 1 307199
0 0 3 0 3 0 10 20
5 0 5 3 5 0 10 6450

//--- verif/raster_tb.sv
// Rasteriser testbench
`timescale 1ns/1ns

module raster_tb;

	localparam int FRAME_WIDTH = 640;
	localparam int PIX_ADDR_W  = 19;
	localparam int MAX_CASES   = 32;

	logic                              clk;
	logic                              reset;
	logic                              wb_cyc;
	logic                              wb_stb;
	logic                              wb_we;
	logic [raster_pkg::REG_ADDR_W-1:0] wb_adr;
	logic [31:0]                       wb_dat_w;
	logic [31:0]                       wb_dat_r;
	logic                              wb_ack;
	logic                              pix_valid;
	logic [PIX_ADDR_W-1:0]             pix_addr;
	logic                              pix_ready;

	int          vtx [MAX_CASES][6]; // x1 y1 x2 y2 x3 y3.
	int          exp_count [MAX_CASES];
	int unsigned exp_sum [MAX_CASES];
	int          num_cases = 0;
	int          errors = 0;
	int          tests_ok = 0;
	int          cycles = 0;
	int          limit = 0;
	logic [31:0] lfsr = 32'hf490;
	logic        stall;
	int          got_count = 0;
	logic [31:0] got_sum = '0;
	logic [31:0] first_addr = '0;
	logic [31:0] last_addr = '0;
	string       vtx_name [6] = '{"x1", "y1", "x2", "y2", "x3", "y3"};

	raster_top #(.FRAME_WIDTH(FRAME_WIDTH), .PIX_ADDR_W(PIX_ADDR_W)) UUT (
		.clk(clk), .reset(reset),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.pix_valid(pix_valid), .pix_addr(pix_addr), .pix_ready(pix_ready)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit)
		begin
			$display("Run stopped after %0d cycles without finishing", cycles);
			$display("Verification failed");
			$finish;
		end
	end

	// Galois LFSR stepped once per bit taken.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// Pixel sink. Ready changes here and transfers are recorded for the next rising edge.
	always @(negedge clk)
	begin
		stall = lfsr[0];
		lfsr = lfsr_next(lfsr);
		stall = stall && lfsr[0]; // Stall when both bits are set.
		lfsr = lfsr_next(lfsr);
		pix_ready = !stall;
		if (reset && pix_valid && pix_ready)
		begin
			if (got_count == 0)
			begin
				first_addr = 32'(pix_addr);
			end
			last_addr = 32'(pix_addr);
			got_sum = got_sum + 32'(pix_addr);
			got_count++;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s: got %08h, expected %08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic bus_write(input logic [2:0] adr, input logic [31:0] data);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = data;
		do @(negedge clk); while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic bus_read(input logic [2:0] adr, output logic [31:0] data);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		do @(negedge clk); while (!wb_ack);
		data = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic load_cases();
		int    fd;
		int    n;
		int    total;
		string line;
		total = 0;
		fd = $fopen("verif/raster_cases.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the case file verif/raster_cases.txt");
			errors++;
			return;
		end
		while (!$feof(fd) && num_cases < MAX_CASES)
		begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 0 && line[0] != "#")
			begin
				n = $sscanf(line, "%d %d %d %d %d %d %d %d",
					vtx[num_cases][0], vtx[num_cases][1], vtx[num_cases][2],
					vtx[num_cases][3], vtx[num_cases][4], vtx[num_cases][5],
					exp_count[num_cases], exp_sum[num_cases]);
				if (n == 8)
				begin
					total = total + 4 * exp_count[num_cases] + 50;
					num_cases++;
				end
			end
		end
		$fclose(fd);
		limit = num_cases * total;
	endtask

	task automatic run_case(input int i);
		logic [31:0] rd;
		int          errs_before;
		errs_before = errors;
		for (int k = 0; k < 6; k++)
		begin
			bus_write(raster_pkg::REG_X1 + 3'(k), 32'(vtx[i][k]));
		end
		for (int k = 0; k < 6; k++)
		begin
			bus_read(raster_pkg::REG_X1 + 3'(k), rd);
			check_value({vtx_name[k], " readback"}, rd, {16'h0, 16'(vtx[i][k])});
		end
		bus_read(raster_pkg::REG_STATUS, rd);
		check_value("busy before start", 32'(rd[raster_pkg::STAT_BUSY_BIT]), 32'd0);
		got_count = 0;
		got_sum = '0;
		bus_write(raster_pkg::REG_CTRL, 32'd1);
		bus_read(raster_pkg::REG_STATUS, rd);
		check_value("busy during run", 32'(rd[raster_pkg::STAT_BUSY_BIT]), 32'd1);
		bus_write(raster_pkg::REG_CTRL, 32'd1); // Lands while busy.
		do
		begin
			bus_read(raster_pkg::REG_STATUS, rd);
		end
		while (rd[raster_pkg::STAT_BUSY_BIT]);
		check_value("status count",
			32'(rd[raster_pkg::STAT_COUNT_MSB:raster_pkg::STAT_COUNT_LSB]), exp_count[i]);
		check_value("pixel count", got_count, exp_count[i]);
		check_value("address sum", got_sum, exp_sum[i]);
		check_value("first pix_addr", first_addr, FRAME_WIDTH * vtx[i][1] + vtx[i][0]);
		check_value("last pix_addr", last_addr, FRAME_WIDTH * vtx[i][5] + vtx[i][4]);
		if (errors == errs_before)
		begin
			tests_ok++;
		end
		$display("Test %0d (%0d,%0d) (%0d,%0d) (%0d,%0d) %0d pixels %s", i,
			vtx[i][0], vtx[i][1], vtx[i][2], vtx[i][3], vtx[i][4], vtx[i][5],
			got_count, (errors == errs_before) ? "ok" : "mismatch");
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		pix_ready = 1'b0;
		load_cases();
		repeat (4) @(negedge clk);
		reset = 1'b1;
		for (int i = 0; i < num_cases; i++)
		begin
			run_case(i);
		end
		if (num_cases == 0)
		begin
			$display("No test cases were read");
			errors++;
		end
		$display("Tests %0d, passed %0d, errors %0d", num_cases, tests_ok, errors);
		if (errors == 0)
		begin
			$display("Verification passed");
		end
		else
		begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
